// ==== include/video_settings.svh ====
/* Bus widths and memory map of the video subsystem.
   VRAM holds up to 2K codes and VROM offsets are 12 bits, so both windows fit in 17 bits */
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// Wishbone word address and data widths
`define WB_ADDR_WIDTH   17
`define DATA_WIDTH      8

// Memory windows seen by the fetch controller
`define VRAM_BASE       17'h08000
`define VROM_BASE       17'h10000

// CRTC register addresses, light pen pair included
`define CRTC_REG_COUNT  18

// Two character bytes per load
`define DOT_SR_WIDTH    16

`endif

// ==== rtl/wb_bus_pkg.sv ====
/* Types shared by the Wishbone controller and peripheral. Widths come from the settings header */
`include "video_settings.svh"

package wb_bus_pkg;

    typedef logic [`WB_ADDR_WIDTH-1:0] wb_addr_t;       // Word address on the bus
    typedef logic [`DATA_WIDTH-1:0]    wb_data_t;       // One byte per bus word

    // Fetch controller bus phases
    typedef enum logic [1:0] {
        IDLE,                                           // No cycle open
        REQ,                                            // Strobe out, waiting for stall low
        WAIT                                            // Request taken, waiting for ack
    } fetch_state_t;

    // Order of the four reads in a character burst
    typedef enum logic [1:0] {
        EVEN_RAM = 2'd0,                                // Even character code
        EVEN_ROM = 2'd1,                                // Even character pixels
        ODD_RAM  = 2'd2,                                // Odd character code
        ODD_ROM  = 2'd3                                 // Odd character pixels
    } fetch_slot_t;

endpackage

// ==== rtl/crtc_pkg.sv ====
/* CRTC address types and register indices. Cursor, light pen and interlace registers
   are stored but have no effect */
package crtc_pkg;

    typedef logic [13:0] crtc_ma_t;                     // MA12 inverts video, MA13 picks charset
    typedef logic [4:0]  crtc_ra_t;                     // Scanline within a character row
    typedef logic [4:0]  crtc_reg_idx_t;                // Value of the address register

    // Registers used by the timing logic
    localparam crtc_reg_idx_t R_H_TOTAL     = 5'd0;     // Characters per line minus one
    localparam crtc_reg_idx_t R_H_DISPLAYED = 5'd1;     // Visible characters per line
    localparam crtc_reg_idx_t R_H_SYNC_POS  = 5'd2;     // Hsync start column
    localparam crtc_reg_idx_t R_SYNC_WIDTH  = 5'd3;     // Low nibble is hsync width
    localparam crtc_reg_idx_t R_V_TOTAL     = 5'd4;     // Rows per frame minus one
    localparam crtc_reg_idx_t R_V_DISPLAYED = 5'd6;     // Visible rows
    localparam crtc_reg_idx_t R_V_SYNC_POS  = 5'd7;     // Vsync start row
    localparam crtc_reg_idx_t R_MAX_SCAN    = 5'd9;     // Scanlines per row minus one
    localparam crtc_reg_idx_t R_START_HI    = 5'd12;    // Frame start address, bits 13..8
    localparam crtc_reg_idx_t R_START_LO    = 5'd13;    // Frame start address, bits 7..0

endpackage

// ==== rtl/video_crtc.sv ====
/* 6545-style CRTC without cursor, light pen, interlace or status flags; status reads zero.
   The Wishbone port is read only and acks every request one cycle later */
`timescale 1ns/100ps
`include "video_settings.svh"

module video_crtc
    import wb_bus_pkg::*;
    import crtc_pkg::*;
(
    input  logic     wb_clock_i,
    input  logic     arst_n_i,
    input  wb_addr_t wb_addr_i,                         // Low 5 bits select the register
    input  logic     wb_cycle_i,
    input  logic     wb_strobe_i,
    output wb_data_t wb_data_o,                         // Valid with wb_ack_o
    output logic     wb_ack_o,
    input  logic     crtc_clk_en_i,                     // Character clock enable
    input  logic     crtc_cs_i,
    input  logic     crtc_we_i,                         // 1 = CPU write
    input  logic     crtc_rs_i,                         // 0 = address reg, 1 = data reg
    input  wb_data_t crtc_data_i,
    output wb_data_t crtc_data_o,
    output logic     crtc_data_oe_o,                    // CPU is reading
    output logic     h_sync_o,                          // Active high
    output logic     v_sync_o,                          // Active high
    output logic     de_o,
    output crtc_ma_t ma_o,
    output crtc_ra_t ra_o
);
    wb_data_t      regs [`CRTC_REG_COUNT];              // CPU programmed register file
    crtc_reg_idx_t addr_reg;
    logic [7:0]    h_count;                             // Character within the line
    crtc_ra_t      ra_count;
    logic [6:0]    row_count;                           // Character row within the frame
    logic [6:0]    next_row;
    crtc_ma_t      row_start;                           // MA of column 0 in this row
    logic [3:0]    vs_count;
    logic          vs_on;
    logic          line_end;
    logic          row_end;
    logic          frame_end;
    logic          vs_start;
    logic [7:0]    h_off;                               // Distance past hsync start

    // Unimplemented indices read back as zero
    function automatic wb_data_t reg_read(crtc_reg_idx_t idx);
        reg_read = (int'(idx) < `CRTC_REG_COUNT) ? regs[idx] : '0;
    endfunction

    // CPU write port
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            addr_reg <= '0;
            for (int i = 0; i < `CRTC_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (crtc_cs_i && crtc_we_i) begin
            if (!crtc_rs_i) begin
                addr_reg <= crtc_data_i[4:0];
            end else if (int'(addr_reg) < `CRTC_REG_COUNT) begin
                regs[addr_reg] <= crtc_data_i;
            end
        end
    end

    assign crtc_data_o    = crtc_rs_i ? reg_read(addr_reg) : '0;    // Status reads zero
    assign crtc_data_oe_o = crtc_cs_i && !crtc_we_i;

    assign line_end  = crtc_clk_en_i && (h_count == regs[R_H_TOTAL]);
    assign row_end   = line_end && (ra_count == regs[R_MAX_SCAN][4:0]);
    assign frame_end = row_end && (row_count == regs[R_V_TOTAL][6:0]);
    assign next_row  = frame_end ? 7'd0 : row_count + 7'd1;
    assign vs_start  = row_end && (next_row == regs[R_V_SYNC_POS][6:0]);

    // Horizontal, raster and row counters
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            h_count   <= '0;
            ra_count  <= '0;
            row_count <= '0;
            row_start <= '0;
        end else if (crtc_clk_en_i) begin
            h_count <= line_end ? 8'd0 : h_count + 8'd1;
            if (line_end) begin
                ra_count <= row_end ? 5'd0 : ra_count + 5'd1;
            end
            if (row_end) begin
                row_count <= next_row;
            end
            if (frame_end) begin
                row_start <= {regs[R_START_HI][5:0], regs[R_START_LO]};     // Reload frame start
            end else if (row_end) begin
                row_start <= row_start + {6'd0, regs[R_H_DISPLAYED]};       // Next text row
            end
        end
    end

    // Vsync lasts 16 scanlines from the first line of R_V_SYNC_POS
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vs_on    <= 1'b0;
            vs_count <= '0;
        end else if (line_end) begin
            if (vs_start) begin
                vs_on    <= 1'b1;
                vs_count <= '0;
            end else if (vs_on) begin
                vs_count <= vs_count + 4'd1;
                if (vs_count == 4'd15) begin
                    vs_on <= 1'b0;
                end
            end
        end
    end

    assign h_off    = h_count - regs[R_H_SYNC_POS];
    assign h_sync_o = (h_count >= regs[R_H_SYNC_POS]) && (h_off < {4'd0, regs[R_SYNC_WIDTH][3:0]});
    assign v_sync_o = vs_on;
    assign de_o     = (h_count < regs[R_H_DISPLAYED]) && (row_count < regs[R_V_DISPLAYED][6:0]);
    assign ma_o     = row_start + crtc_ma_t'(h_count);
    assign ra_o     = ra_count;

    // Register read-back, one request per ack
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_cycle_i && wb_strobe_i;
        end
    end

    always_ff @(posedge wb_clock_i) begin
        if (wb_cycle_i && wb_strobe_i) begin
            wb_data_o <= reg_read(crtc_reg_idx_t'(wb_addr_i[4:0]));
        end
    end

    // The management controller issues single reads, never back to back
    a_ack_single: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        wb_ack_o |=> !wb_ack_o);

endmodule

// ==== rtl/video_fetch.sv ====
/* Wishbone B4 pipelined reader, one request outstanding at a time.
   A character clock during a burst is ignored, so the burst must end within one character */
`timescale 1ns/100ps
`include "video_settings.svh"

module video_fetch
    import wb_bus_pkg::*;
    import crtc_pkg::*;
(
    input  logic                     wb_clock_i,
    input  logic                     arst_n_i,
    input  logic                     crtc_clk_en_i,    // Starts a burst
    input  logic                     col_80_mode_i,
    input  logic                     graphic_i,         // Charset select into VROM
    input  crtc_ma_t                 ma_i,
    input  crtc_ra_t                 ra_i,
    output wb_addr_t                 wb_addr_o,
    input  wb_data_t                 wb_data_i,
    output logic                     wb_we_o,
    output logic                     wb_cycle_o,
    output logic                     wb_strobe_o,
    input  logic                     wb_stall_i,
    input  logic                     wb_ack_i,
    output logic [`DOT_SR_WIDTH-1:0] pixels_o,          // {even ROM, odd ROM}
    output logic [1:0]               reverse_o          // {even, odd} code bit 7
);
    fetch_state_t state;
    fetch_slot_t  slot;
    wb_data_t     fetched [4];                          // Bytes indexed by slot
    wb_data_t     code;                                 // Code behind the current ROM read
    logic [10:0]  char_idx;

    always_comb begin
        code     = (slot == EVEN_ROM) ? fetched[EVEN_RAM] : fetched[ODD_RAM];
        char_idx = col_80_mode_i ? {ma_i[9:0], slot == ODD_RAM} : {1'b0, ma_i[9:0]};
        if (slot == EVEN_RAM || slot == ODD_RAM) begin
            wb_addr_o = `VRAM_BASE + wb_addr_t'(char_idx);
        end else begin
            wb_addr_o = `VROM_BASE + wb_addr_t'({ma_i[13], graphic_i, code[6:0], ra_i[2:0]});
        end
    end

    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state       <= IDLE;
            slot        <= EVEN_RAM;
            wb_cycle_o  <= 1'b0;
            wb_strobe_o <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (crtc_clk_en_i) begin
                        wb_cycle_o  <= 1'b1;
                        wb_strobe_o <= 1'b1;
                        slot        <= EVEN_RAM;
                        state       <= REQ;
                    end
                end
                REQ: begin
                    if (!wb_stall_i) begin                  // Request accepted
                        wb_strobe_o <= 1'b0;
                        state       <= WAIT;
                    end
                end
                WAIT: begin
                    if (wb_ack_i) begin
                        if (slot == ODD_ROM) begin          // Burst done
                            wb_cycle_o <= 1'b0;
                            state      <= IDLE;
                        end else begin
                            slot        <= fetch_slot_t'(slot + 2'd1);
                            wb_strobe_o <= 1'b1;
                            state       <= REQ;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge wb_clock_i) begin
        if (state == WAIT && wb_ack_i) begin
            fetched[slot] <= wb_data_i;
        end
    end

    assign wb_we_o   = 1'b0;                            // Read only master
    assign pixels_o  = {fetched[EVEN_ROM], fetched[ODD_ROM]};
    assign reverse_o = {fetched[EVEN_RAM][7], fetched[ODD_RAM][7]};

    a_strobe_in_cycle: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        wb_strobe_o |-> wb_cycle_o);

endmodule

// ==== rtl/video_dotgen.sv ====
/* Pixel shifter for two characters per load, MSB first.
   Reverse, inversion and blank are sampled with the pixels on load_sr_i */
`timescale 1ns/100ps
`include "video_settings.svh"

module video_dotgen (
    input  logic                     wb_clock_i,
    input  logic                     arst_n_i,
    input  logic                     pixel_clk_en_i,    // One shift per enable
    input  logic                     load_sr_i,
    input  logic [`DOT_SR_WIDTH-1:0] pixels_i,          // {even ROM, odd ROM}
    input  logic [1:0]               reverse_i,         // {even, odd}
    input  logic                     blank_i,
    input  logic                     invert_i,          // MA12, low inverts
    output logic                     video_o            // Active high dot
);
    localparam int CNT_W = $clog2(`DOT_SR_WIDTH);

    logic [`DOT_SR_WIDTH-1:0] shift_reg;
    logic [1:0]               reverse;
    logic                     invert;
    logic                     blank;
    logic [CNT_W-1:0]         shift_cnt;                // Shifts since load
    logic                     cur_reverse;

    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            blank     <= 1'b1;                          // Dark until first load
            shift_cnt <= '0;
        end else if (load_sr_i) begin
            blank     <= blank_i;
            shift_cnt <= '0;
        end else if (pixel_clk_en_i) begin
            shift_cnt <= shift_cnt + 1'b1;
        end
    end

    always_ff @(posedge wb_clock_i) begin
        if (load_sr_i) begin
            shift_reg <= pixels_i;
            reverse   <= reverse_i;
            invert    <= invert_i;
        end else if (pixel_clk_en_i) begin
            shift_reg <= {shift_reg[`DOT_SR_WIDTH-2:0], 1'b0};
        end
    end

    // Odd character takes over in the second half
    assign cur_reverse = shift_cnt[CNT_W-1] ? reverse[0] : reverse[1];
    assign video_o     = blank ? 1'b0 : shift_reg[`DOT_SR_WIDTH-1] ^ cur_reverse ^ !invert;

endmodule

// ==== rtl/video.sv ====
/* Video top level. config_crt_i sets polarity: 0 = 12" CRT, 1 = 9" CRT.
   Syncs lag the CRTC by one load_sr1_i so they line up with the fetched pixels */
`timescale 1ns/100ps
`include "video_settings.svh"

module video
    import wb_bus_pkg::*;
    import crtc_pkg::*;
(
    input  logic     wb_clock_i,
    input  logic     arst_n_i,
    input  logic     clk8_en_i,                         // 40 column pixel rate
    input  logic     clk16_en_i,                        // 80 column pixel rate
    input  logic     load_sr1_i,                        // Dot shifter load
    input  logic     config_crt_i,
    input  logic     col_80_mode_i,
    input  logic     graphic_i,
    output wb_addr_t wb_addr_o,                         // Fetch master
    input  wb_data_t wb_data_i,
    output logic     wb_we_o,
    output logic     wb_cycle_o,
    output logic     wb_strobe_o,
    input  logic     wb_stall_i,
    input  logic     wb_ack_i,
    input  wb_addr_t wb_addr_i,                         // Register read-back port
    output wb_data_t wb_data_o,
    input  logic     wb_cycle_i,
    input  logic     wb_strobe_i,
    output logic     wb_ack_o,
    input  logic     crtc_clk_en_i,
    input  logic     crtc_cs_i,
    input  logic     crtc_we_i,
    input  logic     crtc_rs_i,
    input  wb_data_t crtc_data_i,
    output wb_data_t crtc_data_o,
    output logic     crtc_data_oe_o,
    output logic     h_sync_o,
    output logic     v_sync_o,
    output logic     video_o
);
    crtc_ma_t                 ma;
    crtc_ra_t                 ra;
    logic                     de;
    logic                     crtc_h_sync;
    logic                     crtc_v_sync;
    logic [`DOT_SR_WIDTH-1:0] pixels;
    logic [1:0]               reverse;
    logic                     pixel_clk_en;
    logic                     dot;

    video_crtc u_crtc (
        .wb_clock_i, .arst_n_i, .wb_addr_i, .wb_cycle_i, .wb_strobe_i, .wb_data_o, .wb_ack_o,
        .crtc_clk_en_i, .crtc_cs_i, .crtc_we_i, .crtc_rs_i, .crtc_data_i, .crtc_data_o,
        .crtc_data_oe_o,
        .h_sync_o (crtc_h_sync),
        .v_sync_o (crtc_v_sync),
        .de_o     (de),
        .ma_o     (ma),
        .ra_o     (ra)
    );

    video_fetch u_fetch (
        .wb_clock_i, .arst_n_i, .crtc_clk_en_i, .col_80_mode_i, .graphic_i,
        .ma_i      (ma),
        .ra_i      (ra),
        .wb_addr_o, .wb_data_i, .wb_we_o, .wb_cycle_o, .wb_strobe_o, .wb_stall_i, .wb_ack_i,
        .pixels_o  (pixels),
        .reverse_o (reverse)
    );

    assign pixel_clk_en = col_80_mode_i ? clk16_en_i : clk8_en_i;

    video_dotgen u_dotgen (
        .wb_clock_i, .arst_n_i,
        .pixel_clk_en_i (pixel_clk_en),
        .load_sr_i      (load_sr1_i),
        .pixels_i       (pixels),
        .reverse_i      (reverse),
        .blank_i        (!de || ra[3] || ra[4]),        // ROM has 8 scanlines only
        .invert_i       (ma[12]),
        .video_o        (dot)
    );

    // 9" wants active high sync, 12" active low
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            h_sync_o <= 1'b0;
            v_sync_o <= 1'b0;
        end else if (load_sr1_i) begin
            h_sync_o <= config_crt_i ^ !crtc_h_sync;
            v_sync_o <= config_crt_i ^ !crtc_v_sync;
        end
    end

    assign video_o = config_crt_i ^ dot;                // Active low on 9"

endmodule

// ==== verif/video_tb.sv ====
/* Directed testbench for the video top level. VRAM and VROM are modeled behind the fetch bus;
   CRTC counters are tracked here from the programmed registers, so no other CPU traffic may run */
`timescale 1ns/100ps
`include "video_settings.svh"

module video_tb
    import wb_bus_pkg::*;
    import crtc_pkg::*;
();
    localparam int BURST_TIMEOUT = 200;                 // Cycles allowed per burst
    localparam int ACK_TIMEOUT   = 20;

    logic     wb_clock_i, arst_n_i, clk8_en_i, clk16_en_i, load_sr1_i, config_crt_i;
    logic     col_80_mode_i, graphic_i, wb_we_o, wb_cycle_o, wb_strobe_o, wb_stall_i, wb_ack_i;
    logic     wb_cycle_i, wb_strobe_i, wb_ack_o, crtc_clk_en_i, crtc_cs_i, crtc_we_i, crtc_rs_i;
    logic     crtc_data_oe_o, h_sync_o, v_sync_o, video_o;
    wb_addr_t wb_addr_o, wb_addr_i;
    wb_data_t wb_data_i, wb_data_o, crtc_data_i, crtc_data_o;

    int       errors = 0;
    string    cur_test = "reset";                      // Shown in error lines
    logic     [15:0] lfsr = 16'd11941;
    logic     stall_random = 1'b0;
    logic     ack_next = 1'b0;
    wb_addr_t ack_addr;
    wb_addr_t bus_addrs [$];                            // Accepted requests of one burst
    int       ack_count;
    logic     [7:0] creg [32];                          // Values written by the CPU
    int       m_h, m_ra, m_row;                         // Tracked CRTC counters
    crtc_ma_t m_row_start;
    int       blank_seen;
    logic     exp_dot0;                                 // First dot of the last loaded character

    video uut (.*);

    initial begin
        wb_clock_i = 1'b0;
        forever #10 wb_clock_i = ~wb_clock_i;
    end

    // Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic wb_data_t mem_read(wb_addr_t a);
        wb_addr_t off;
        if (a >= `VROM_BASE) begin
            off = a - `VROM_BASE;
            mem_read = off[7:0] ^ 8'hA7;                // Character ROM pattern
        end else begin
            off = a - `VRAM_BASE;
            mem_read = off[7:0] ^ 8'h35;                // Screen code pattern
        end
    endfunction

    // Bus slave: stall chosen first, then a request with stall low is acked next cycle
    always @(negedge wb_clock_i) begin
        wb_ack_i = ack_next;
        if (ack_next) begin
            wb_data_i = mem_read(ack_addr);
            ack_count++;
        end
        ack_next = 1'b0;
        if (stall_random) begin
            lfsr = lfsr_step(lfsr);
            wb_stall_i = lfsr[0];
        end else begin
            wb_stall_i = 1'b0;
        end
        if (wb_cycle_o && wb_strobe_o && !wb_stall_i) begin
            ack_next = 1'b1;
            ack_addr = wb_addr_o;
            bus_addrs.push_back(wb_addr_o);
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s, %s: expected %0h, actual %0h", cur_test, name, expected, actual);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout waiting for %s, errors: %0d", what, errors);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic cpu_write(input logic rs, input logic [7:0] data);
        crtc_cs_i   = 1'b1;
        crtc_we_i   = 1'b1;
        crtc_rs_i   = rs;
        crtc_data_i = data;
        @(negedge wb_clock_i);
        crtc_cs_i = 1'b0;
        crtc_we_i = 1'b0;
    endtask

    task automatic set_reg(input int idx, input logic [7:0] value);
        cpu_write(1'b0, 8'(idx));
        cpu_write(1'b1, value);
        creg[idx] = value;
    endtask

    task automatic wb_read(input int idx, output logic [7:0] data);
        int t;
        wb_addr_i   = wb_addr_t'(idx);
        wb_cycle_i  = 1'b1;
        wb_strobe_i = 1'b1;
        @(negedge wb_clock_i);
        wb_strobe_i = 1'b0;                             // Single request
        for (t = 0; t < ACK_TIMEOUT && !wb_ack_o; t++) @(negedge wb_clock_i);
        if (!wb_ack_o) abort_on_timeout("peripheral ack");
        data = wb_data_o;
        wb_cycle_i = 1'b0;
        @(negedge wb_clock_i);
    endtask

    task automatic pulse_pixel(input logic col80);
        clk8_en_i  = !col80;
        clk16_en_i = col80;
        @(negedge wb_clock_i);
        clk8_en_i  = 1'b0;
        clk16_en_i = 1'b0;
    endtask

    task automatic model_step();
        if (m_h == int'(creg[R_H_TOTAL])) begin
            m_h = 0;
            if (m_ra == int'(creg[R_MAX_SCAN][4:0])) begin
                m_ra = 0;
                if (m_row == int'(creg[R_V_TOTAL][6:0])) begin
                    m_row = 0;
                    m_row_start = {creg[R_START_HI][5:0], creg[R_START_LO]};
                end else begin
                    m_row++;
                    m_row_start = m_row_start + crtc_ma_t'(creg[R_H_DISPLAYED]);
                end
            end else begin
                m_ra++;
            end
        end else begin
            m_h++;
        end
    endtask

    // CRTC hsync for the tracked column
    function automatic logic model_hsync();
        model_hsync = (m_h >= int'(creg[R_H_SYNC_POS]))
                      && (m_h - int'(creg[R_H_SYNC_POS]) < int'(creg[R_SYNC_WIDTH][3:0]));
    endfunction

    // CRTC vsync, 16 scanlines from the sync row, window assumed inside the frame
    function automatic logic model_vsync();
        int per_row;
        int scan;
        int first;
        per_row = int'(creg[R_MAX_SCAN][4:0]) + 1;
        scan    = m_row * per_row + m_ra;
        first   = int'(creg[R_V_SYNC_POS][6:0]) * per_row;
        model_vsync = (scan >= first) && (scan < first + 16);
    endfunction

    // One character: burst, address check, load, sync check, 16 dots
    task automatic char_step(input logic col80);
        crtc_ma_t    ma;
        logic [10:0] idx_e, idx_o;
        logic [7:0]  ce, co, pe, po;
        logic [11:0] rom_e, rom_o;
        wb_addr_t    exp_addr [4];
        logic        blank, dot;
        logic [15:0] pix;
        int          t;
        bus_addrs.delete();
        ack_count = 0;
        crtc_clk_en_i = 1'b1;
        @(negedge wb_clock_i);
        crtc_clk_en_i = 1'b0;
        model_step();
        for (t = 0; t < BURST_TIMEOUT && wb_cycle_o; t++) @(negedge wb_clock_i);
        if (wb_cycle_o) abort_on_timeout("end of burst");
        ma    = m_row_start + crtc_ma_t'(m_h);
        idx_e = col80 ? {ma[9:0], 1'b0} : {1'b0, ma[9:0]};
        idx_o = col80 ? {ma[9:0], 1'b1} : {1'b0, ma[9:0]};
        ce    = idx_e[7:0] ^ 8'h35;
        co    = idx_o[7:0] ^ 8'h35;
        rom_e = {ma[13], graphic_i, ce[6:0], 3'(m_ra)};
        rom_o = {ma[13], graphic_i, co[6:0], 3'(m_ra)};
        exp_addr = '{`VRAM_BASE + wb_addr_t'(idx_e), `VROM_BASE + wb_addr_t'(rom_e),
                     `VRAM_BASE + wb_addr_t'(idx_o), `VROM_BASE + wb_addr_t'(rom_o)};
        check("burst acks", 4, ack_count);
        check("burst requests", 4, bus_addrs.size());
        check("write enable", 0, wb_we_o);
        for (int i = 0; i < 4; i++) begin
            check($sformatf("address slot %0d", i), exp_addr[i],
                  (bus_addrs.size() > i) ? bus_addrs[i] : '1);
        end
        pe     = rom_e[7:0] ^ 8'hA7;
        po     = rom_o[7:0] ^ 8'hA7;
        pix    = {pe, po};
        blank  = !((m_h < int'(creg[R_H_DISPLAYED])) && (m_row < int'(creg[R_V_DISPLAYED])))
                 || (m_ra >= 8);
        exp_dot0 = blank ? 1'b0 : pix[15] ^ ce[7] ^ !ma[12];
        if (blank) blank_seen++;
        load_sr1_i = 1'b1;
        @(negedge wb_clock_i);
        load_sr1_i = 1'b0;
        check("h_sync_o", config_crt_i ^ !model_hsync(), h_sync_o);
        check("v_sync_o", config_crt_i ^ !model_vsync(), v_sync_o);
        for (int k = 0; k < 16; k++) begin
            dot = blank ? 1'b0 : pix[15-k] ^ ((k < 8) ? ce[7] : co[7]) ^ !ma[12];
            check($sformatf("video_o dot %0d", k), config_crt_i ^ dot, video_o);
            pulse_pixel(col80);
        end
    endtask

    task automatic readback_registers();
        logic [7:0] vals [10] = '{8'd9, 8'd6, 8'd7, 8'd2, 8'd3, 8'd2, 8'd2, 8'd9, 8'h31, 8'h40};
        int         idxs [10] = '{R_H_TOTAL, R_H_DISPLAYED, R_H_SYNC_POS, R_SYNC_WIDTH,
                                  R_V_TOTAL, R_V_DISPLAYED, R_V_SYNC_POS, R_MAX_SCAN,
                                  R_START_HI, R_START_LO};
        logic [7:0] data;
        cur_test = "registers";
        for (int i = 0; i < 10; i++) set_reg(idxs[i], vals[i]);
        for (int i = 0; i < 10; i++) begin
            cpu_write(1'b0, 8'(idxs[i]));
            crtc_cs_i = 1'b1;                           // CPU read of the data register
            crtc_rs_i = 1'b1;
            @(negedge wb_clock_i);
            check($sformatf("cpu read reg %0d", idxs[i]), vals[i], crtc_data_o);
            check("crtc_data_oe_o", 1, crtc_data_oe_o);
            crtc_cs_i = 1'b0;
            wb_read(idxs[i], data);
            check($sformatf("wb read reg %0d", idxs[i]), vals[i], data);
        end
        cpu_write(1'b0, 8'd20);
        crtc_rs_i = 1'b1;
        @(negedge wb_clock_i);
        check("cpu read reg 20", 0, crtc_data_o);
        wb_read(20, data);
        check("wb read reg 20", 0, data);
        check("crtc_data_oe_o idle", 0, crtc_data_oe_o);
    endtask

    task automatic measure_hsync_period();
        int   chars = 0;
        int   last_edge = -1;
        int   edges = 0;
        logic prev;
        cur_test      = "hsync period";
        config_crt_i  = 1'b0;
        col_80_mode_i = 1'b0;
        prev = h_sync_o;
        repeat (35) begin
            char_step(1'b0);
            chars++;
            if (prev && !h_sync_o) begin                // CRTC sync rising
                if (last_edge >= 0) check("hsync period", 10, chars - last_edge);
                last_edge = chars;
                edges++;
            end
            prev = h_sync_o;
        end
        check("hsync edges seen", 1, edges >= 2);
    endtask

    task automatic run_display(input logic col80, input logic crt, input logic stall,
                               input logic graphic, input int chars);
        cur_test      = $sformatf("display col80=%0d crt=%0d stall=%0d", col80, crt, stall);
        col_80_mode_i = col80;
        config_crt_i  = crt;
        stall_random  = stall;
        graphic_i     = graphic;
        blank_seen    = 0;
        repeat (chars) char_step(col80);
        check("blanked characters seen", 1, blank_seen > 0);
        stall_random = 1'b0;
    endtask

    // Reload the last character, then flip the CRT option
    task automatic toggle_polarity();
        cur_test   = "polarity";
        load_sr1_i = 1'b1;
        @(negedge wb_clock_i);
        load_sr1_i = 1'b0;
        check("video_o before toggle", config_crt_i ^ exp_dot0, video_o);
        config_crt_i = !config_crt_i;
        @(negedge wb_clock_i);
        check("video_o inverted", config_crt_i ^ exp_dot0, video_o);
        load_sr1_i = 1'b1;
        @(negedge wb_clock_i);
        load_sr1_i = 1'b0;
        check("h_sync_o inverted", config_crt_i ^ !model_hsync(), h_sync_o);
        check("v_sync_o inverted", config_crt_i ^ !model_vsync(), v_sync_o);
    endtask

    initial begin
        arst_n_i      = 1'b0;
        clk8_en_i     = 1'b0;
        clk16_en_i    = 1'b0;
        load_sr1_i    = 1'b0;
        config_crt_i  = 1'b0;
        col_80_mode_i = 1'b0;
        graphic_i     = 1'b0;
        wb_data_i     = '0;
        wb_stall_i    = 1'b0;
        wb_ack_i      = 1'b0;
        wb_addr_i     = '0;
        wb_cycle_i    = 1'b0;
        wb_strobe_i   = 1'b0;
        crtc_clk_en_i = 1'b0;
        crtc_cs_i     = 1'b0;
        crtc_we_i     = 1'b0;
        crtc_rs_i     = 1'b0;
        crtc_data_i   = '0;
        foreach (creg[i]) creg[i] = '0;
        m_h = 0;
        m_ra = 0;
        m_row = 0;
        m_row_start = '0;
        exp_dot0 = 1'b0;
        repeat (16) @(posedge wb_clock_i);
        @(negedge wb_clock_i);
        arst_n_i = 1'b1;
        check("cycle after reset", 0, wb_cycle_o);
        check("strobe after reset", 0, wb_strobe_o);
        check("ack after reset", 0, wb_ack_o);
        check("data oe after reset", 0, crtc_data_oe_o);
        check("video after reset", 0, video_o);

        readback_registers();
        measure_hsync_period();
        run_display(1'b0, 1'b0, 1'b0, 1'b0, 120);
        run_display(1'b1, 1'b1, 1'b1, 1'b1, 250);
        toggle_polarity();
        run_display(1'b0, config_crt_i, 1'b1, 1'b0, 150);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
rtl/wb_bus_pkg.sv
rtl/crtc_pkg.sv
rtl/video_crtc.sv
rtl/video_fetch.sv
rtl/video_dotgen.sv
rtl/video.sv
verif/video_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the video testbench with Verilator; exit status reflects the result

cd "$(dirname "$0")" || exit 1

verilator --binary -sv --assert -f all.f --top-module video_tb \
    --Mdir obj_dir -o video_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/video_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi
